// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rename_unit_tb
FILELIST  ?= rename_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) tests/rename_unit_tasks.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/free_select.sv ====
`timescale 1ns/10ps

// lowest-index-first allocation from the free list
// lane 0 gets the lowest free register, lane 1 the next one up
module free_select
    import rename_pkg::*;
(
    input  logic [phys_regs-1:0]     free_list,   // 1 = register is free
    output phys_idx_t [lanes-1:0]    alloc_tag,   // tag offered to each lane
    output lane_count_t              free_count   // lanes that can be served, capped at lanes
);

    logic [lanes:0][phys_regs-1:0]   remaining;   // free bits still unclaimed before each lane
    logic [lanes-1:0][phys_regs-1:0] grant;       // one-hot pick per lane

    // peel off the lowest set bit once per lane
    always_comb begin
        remaining[0] = free_list;
        for (int l = 0; l < lanes; l++) begin
            grant[l]         = remaining[l] & (~remaining[l] + 1'b1); // isolate lowest one
            remaining[l + 1] = remaining[l] & ~grant[l];
        end
    end

    // one-hot to index, OR form since only one bit can be set
    always_comb begin
        for (int l = 0; l < lanes; l++) begin
            alloc_tag[l] = '0;
            for (int b = 0; b < phys_regs; b++) begin
                if (grant[l][b]) begin
                    alloc_tag[l] = alloc_tag[l] | phys_idx_t'(b);
                end
            end
        end
    end

    // a lane is servable when it found a free bit
    always_comb begin
        free_count = '0;
        for (int l = 0; l < lanes; l++) begin
            free_count = free_count + lane_count_t'(|grant[l]);
        end
    end

endmodule

// ==== logic/map_table.sv ====
`timescale 1ns/10ps

// architectural to physical map with one checkpoint copy
module map_table
    import rename_pkg::*;
(
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [lanes-1:0]                      write_en,
    input  arch_idx_t [lanes-1:0]                 write_arch,
    input  phys_idx_t [lanes-1:0]                 write_phys,
    input  arch_idx_t [lanes-1:0][map_reads-1:0]  read_arch,   // src1, src2, dest per lane
    output phys_idx_t [lanes-1:0][map_reads-1:0]  read_phys,
    input  logic                                  checkpoint,
    input  logic                                  restore
);

    phys_idx_t map_q [arch_regs];      // live mappings
    phys_idx_t map_snap [arch_regs];   // copy taken at checkpoint
    phys_idx_t map_next [arch_regs];   // live table after this cycle's writes

    // later lanes win when two lanes write the same arch reg
    always_comb begin
        map_next = map_q;
        for (int l = 0; l < lanes; l++) begin
            if (write_en[l]) begin
                map_next[write_arch[l]] = write_phys[l];
            end
        end
    end

    // reads see writes from lower lanes of the same group
    always_comb begin
        for (int l = 0; l < lanes; l++) begin
            for (int p = 0; p < map_reads; p++) begin
                read_phys[l][p] = map_q[read_arch[l][p]];
                for (int w = 0; w < l; w++) begin
                    if (write_en[w] && write_arch[w] == read_arch[l][p]) begin
                        read_phys[l][p] = write_phys[w];  // highest lower lane wins
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < arch_regs; a++) begin
                map_q[a]    <= phys_idx_t'(a);  // identity mapping
                map_snap[a] <= phys_idx_t'(a);
            end
        end else begin
            map_q <= restore ? map_snap : map_next;
            if (checkpoint) begin
                map_snap <= map_next;  // snapshot after this group's renames
            end
        end
    end

endmodule

// ==== logic/phys_reg_tracker.sv ====
`timescale 1ns/10ps

// free list and complete list of the physical register file
// also keeps one free-list snapshot for branch recovery
module phys_reg_tracker
    import rename_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    // allocation from the rename stage
    input  logic [lanes-1:0]       alloc_take,      // lane consumed its tag this cycle
    input  phys_idx_t [lanes-1:0]  alloc_tag,
    // result bus
    input  logic [lanes-1:0]       complete_valid,
    input  phys_idx_t [lanes-1:0]  complete_tag,
    // retirement frees the old mapping
    input  lane_count_t            retire_count,    // lanes below this count are valid
    input  phys_idx_t [lanes-1:0]  retire_tag,
    // branch recovery
    input  logic                   checkpoint,
    input  logic                   restore,
    output logic [phys_regs-1:0]   free_list,
    output logic [phys_regs-1:0]   complete_list
);

    logic [phys_regs-1:0] next_free;      // free list after takes and retires
    logic [phys_regs-1:0] next_complete;
    logic [phys_regs-1:0] free_snapshot;  // free list as of the last checkpoint

    // free list update
    always_comb begin
        next_free = free_list;
        for (int l = 0; l < lanes; l++) begin
            if (alloc_take[l]) begin
                next_free[alloc_tag[l]] = 1'b0;   // handed out to a destination
            end
        end
        for (int l = 0; l < lanes; l++) begin
            if (l < int'(retire_count)) begin
                next_free[retire_tag[l]] = 1'b1;  // old mapping is dead now
            end
        end
    end

    // complete list update
    always_comb begin
        next_complete = complete_list;
        for (int l = 0; l < lanes; l++) begin
            if (complete_valid[l]) begin
                next_complete[complete_tag[l]] = 1'b1;
            end
        end
        // a fresh allocation has no value yet
        for (int l = 0; l < lanes; l++) begin
            if (alloc_take[l]) begin
                next_complete[alloc_tag[l]] = 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // arch regs start mapped one to one onto the low half
            free_list     <= {{(phys_regs - arch_regs){1'b1}}, {arch_regs{1'b0}}};
            complete_list <= {{(phys_regs - arch_regs){1'b0}}, {arch_regs{1'b1}}};
            free_snapshot <= {{(phys_regs - arch_regs){1'b1}}, {arch_regs{1'b0}}};
        end else begin
            complete_list <= next_complete;
            // restore brings back everything that was free at the checkpoint
            free_list <= restore ? (next_free | free_snapshot) : next_free;
            if (checkpoint) begin
                free_snapshot <= next_free;  // includes this group's takes
            end
        end
    end

endmodule

// ==== logic/rename_pkg.sv ====
package rename_pkg;

    // rename width and register file sizes
    localparam int lanes     = 2;   // instructions renamed per cycle
    localparam int arch_regs = 32;  // architectural registers
    localparam int phys_regs = 64;  // physical registers, R10K style

    // index and count widths
    localparam int arch_idx_bits   = 5;  // log2 of arch_regs
    localparam int phys_idx_bits   = 6;  // log2 of phys_regs
    localparam int lane_count_bits = 2;  // holds 0 .. lanes

    // map table read ports per lane
    localparam int map_reads = 3;
    localparam int read_src1 = 0;   // first source
    localparam int read_src2 = 1;   // second source
    localparam int read_dest = 2;   // old mapping of the destination

    typedef logic [arch_idx_bits-1:0]   arch_idx_t;    // architectural register index
    typedef logic [phys_idx_bits-1:0]   phys_idx_t;    // physical register index
    typedef logic [lane_count_bits-1:0] lane_count_t;  // number of lanes in a group

endpackage

// ==== logic/rename_stage.sv ====
`timescale 1ns/10ps

// rename handshake and output register
// one group sits in the output register, the next one waits at the input
module rename_stage
    import rename_pkg::*;
(
    input  logic                                  clock,
    input  logic                                  reset,
    // rename input
    input  logic                                  in_valid,
    input  logic [lanes-1:0]                      in_lane_valid,   // filled from lane 0 up
    input  arch_idx_t [lanes-1:0]                 in_dest,
    input  arch_idx_t [lanes-1:0]                 in_src1,
    input  arch_idx_t [lanes-1:0]                 in_src2,
    input  logic                                  in_checkpoint,
    output logic                                  in_ready,
    // rename output
    output logic                                  out_valid,
    output logic [lanes-1:0]                      out_lane_valid,
    output phys_idx_t [lanes-1:0]                 out_dest_phys,
    output phys_idx_t [lanes-1:0]                 out_old_phys,
    output phys_idx_t [lanes-1:0]                 out_src1_phys,
    output phys_idx_t [lanes-1:0]                 out_src2_phys,
    output logic [lanes-1:0]                      out_src1_ready,
    output logic [lanes-1:0]                      out_src2_ready,
    input  logic                                  out_ready,
    input  logic                                  restore,
    // allocation
    input  lane_count_t                           free_count,
    input  phys_idx_t [lanes-1:0]                 alloc_tag,
    output logic [lanes-1:0]                      alloc_take,
    // map table
    output logic [lanes-1:0]                      map_write_en,
    output arch_idx_t [lanes-1:0]                 map_write_arch,
    output phys_idx_t [lanes-1:0]                 map_write_phys,
    output arch_idx_t [lanes-1:0][map_reads-1:0]  map_read_arch,
    input  phys_idx_t [lanes-1:0][map_reads-1:0]  map_read_phys,
    // readiness
    input  logic [phys_regs-1:0]                  complete_list,
    input  logic [lanes-1:0]                      complete_valid,  // same-cycle results
    input  phys_idx_t [lanes-1:0]                 complete_tag,
    output logic                                  checkpoint
);

    lane_count_t      need_count;  // valid lanes in the offered group
    logic             accept;
    logic [lanes-1:0] src1_ready;
    logic [lanes-1:0] src2_ready;

    // true when the tag is complete now or is on the result bus this cycle
    function automatic logic tag_ready(input phys_idx_t tag);
        logic rdy;
        rdy = complete_list[tag];
        for (int c = 0; c < lanes; c++) begin
            if (complete_valid[c] && complete_tag[c] == tag) begin
                rdy = 1'b1;
            end
        end
        return rdy;
    endfunction

    // true when a lower lane of this group writes the arch reg
    function automatic logic made_in_group(input int lane, input arch_idx_t arch);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < lane; w++) begin
            if (in_lane_valid[w] && in_dest[w] == arch) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always_comb begin
        need_count = '0;
        for (int l = 0; l < lanes; l++) begin
            need_count = need_count + lane_count_t'(in_lane_valid[l]);
        end
    end

    // room when the output is empty or drains at this edge, and enough free tags
    assign in_ready = !restore && (!out_valid || out_ready) && (free_count >= need_count);
    assign accept   = in_valid && in_ready;
    assign checkpoint = accept && in_checkpoint;

    always_comb begin
        for (int l = 0; l < lanes; l++) begin
            alloc_take[l]     = accept && in_lane_valid[l];
            map_write_en[l]   = alloc_take[l];
            map_write_arch[l] = in_dest[l];
            map_write_phys[l] = alloc_tag[l];
            map_read_arch[l][read_src1] = in_src1[l];
            map_read_arch[l][read_src2] = in_src2[l];
            map_read_arch[l][read_dest] = in_dest[l];
            // an in-group producer cannot be done yet
            src1_ready[l] = tag_ready(map_read_phys[l][read_src1])
                            && !made_in_group(l, in_src1[l]);
            src2_ready[l] = tag_ready(map_read_phys[l][read_src2])
                            && !made_in_group(l, in_src2[l]);
        end
    end

    // control
    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (restore) begin
            out_valid <= 1'b0;  // squash the group in flight
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // payload, loaded only on acceptance so it holds under back-pressure
    always_ff @(posedge clock) begin
        if (accept) begin
            out_lane_valid <= in_lane_valid;
            out_src1_ready <= src1_ready;
            out_src2_ready <= src2_ready;
            for (int l = 0; l < lanes; l++) begin
                out_dest_phys[l] <= alloc_tag[l];
                out_old_phys[l]  <= map_read_phys[l][read_dest];
                out_src1_phys[l] <= map_read_phys[l][read_src1];
                out_src2_phys[l] <= map_read_phys[l][read_src2];
            end
        end
    end

endmodule

// ==== logic/rename_unit.sv ====
`timescale 1ns/10ps

// register rename unit, two wide, 32 arch onto 64 phys registers
module rename_unit
    import rename_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    // rename input
    input  logic                   in_valid,
    input  logic [lanes-1:0]       in_lane_valid,
    input  arch_idx_t [lanes-1:0]  in_dest,
    input  arch_idx_t [lanes-1:0]  in_src1,
    input  arch_idx_t [lanes-1:0]  in_src2,
    input  logic                   in_checkpoint,
    output logic                   in_ready,
    // rename output
    output logic                   out_valid,
    output logic [lanes-1:0]       out_lane_valid,
    output phys_idx_t [lanes-1:0]  out_dest_phys,
    output phys_idx_t [lanes-1:0]  out_old_phys,
    output phys_idx_t [lanes-1:0]  out_src1_phys,
    output phys_idx_t [lanes-1:0]  out_src2_phys,
    output logic [lanes-1:0]       out_src1_ready,
    output logic [lanes-1:0]       out_src2_ready,
    input  logic                   out_ready,
    // result bus, retire and branch recovery
    input  logic [lanes-1:0]       complete_valid,
    input  phys_idx_t [lanes-1:0]  complete_tag,
    input  lane_count_t            retire_count,
    input  phys_idx_t [lanes-1:0]  retire_tag,
    input  logic                   restore
);

    logic [phys_regs-1:0]                 free_list;
    logic [phys_regs-1:0]                 complete_list;
    phys_idx_t [lanes-1:0]                alloc_tag;
    lane_count_t                          free_count;
    logic [lanes-1:0]                     alloc_take;
    logic                                 checkpoint;   // accepted group asked for a snapshot
    logic [lanes-1:0]                     map_write_en;
    arch_idx_t [lanes-1:0]                map_write_arch;
    phys_idx_t [lanes-1:0]                map_write_phys;
    arch_idx_t [lanes-1:0][map_reads-1:0] map_read_arch;
    phys_idx_t [lanes-1:0][map_reads-1:0] map_read_phys;

    rename_stage i_stage (
        .clock, .reset,
        .in_valid, .in_lane_valid, .in_dest, .in_src1, .in_src2, .in_checkpoint, .in_ready,
        .out_valid, .out_lane_valid, .out_dest_phys, .out_old_phys,
        .out_src1_phys, .out_src2_phys, .out_src1_ready, .out_src2_ready, .out_ready,
        .restore, .free_count, .alloc_tag, .alloc_take,
        .map_write_en, .map_write_arch, .map_write_phys, .map_read_arch, .map_read_phys,
        .complete_list, .complete_valid, .complete_tag, .checkpoint
    );

    phys_reg_tracker i_tracker (
        .clock, .reset, .alloc_take, .alloc_tag, .complete_valid, .complete_tag,
        .retire_count, .retire_tag, .checkpoint, .restore, .free_list, .complete_list
    );

    free_select i_free_select (
        .free_list, .alloc_tag, .free_count
    );

    map_table i_map (
        .clock, .reset,
        .write_en   (map_write_en),
        .write_arch (map_write_arch),
        .write_phys (map_write_phys),
        .read_arch  (map_read_arch),
        .read_phys  (map_read_phys),
        .checkpoint, .restore
    );

endmodule

// ==== rename_unit.f ====
+incdir+tests
logic/rename_pkg.sv
logic/free_select.sv
logic/phys_reg_tracker.sv
logic/map_table.sv
logic/rename_stage.sv
logic/rename_unit.sv
tests/rename_unit_tb.sv

// ==== tests/rename_unit_tasks.svh ====
// compares one value and stops at the first mismatch
task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
    if (actual !== expected) begin
        $display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, what, actual, expected);
        $display("Simulation FAILED");
        $fatal(1, "value mismatch");
    end
endtask

task automatic timeout_stop(input string what);
    $display("timed out waiting for %s", what);
    $display("Simulation FAILED");
    $fatal(1, "timeout");
endtask

// puts one group on the input at a falling edge
task automatic drive_group(input logic [1:0] lv, input arch_idx_t d0, a0, b0,
                           input arch_idx_t d1, a1, b1, input logic ck);
    in_valid      = 1'b1;
    in_lane_valid = lv;
    in_dest       = {d1, d0};
    in_src1       = {a1, a0};
    in_src2       = {b1, b0};
    in_checkpoint = ck;
endtask

task automatic wait_accept(input int start);
    int waited;
    waited = 0;
    while (n_accepted == start) begin
        @(negedge clock);
        waited++;
        if (waited > wait_limit) timeout_stop("in_ready");
    end
    in_valid      = 1'b0;
    in_checkpoint = 1'b0;
endtask

task automatic send_group(input logic [1:0] lv, input arch_idx_t d0, a0, b0,
                          input arch_idx_t d1, a1, b1, input logic ck);
    int start;
    @(negedge clock);
    start = n_accepted;
    drive_group(lv, d0, a0, b0, d1, a1, b1, ck);
    wait_accept(start);
endtask

// next delivered group lands in got_*
task automatic take_output();
    int start;
    int waited;
    start     = n_delivered;
    waited    = 0;
    out_ready = 1'b1;
    while (n_delivered == start) begin
        @(negedge clock);
        waited++;
        if (waited > wait_limit) timeout_stop("out_valid");
    end
endtask

task automatic expect_blocked(input int cycles);
    int start;
    start = n_accepted;
    repeat (cycles) begin
        @(posedge clock);
        check_value(in_ready, 1'b0, "in_ready while blocked");
    end
    @(negedge clock);
    check_value(n_accepted, start, "groups accepted while blocked");
endtask

task automatic first_group_after_reset();
    send_group(2'b11, 1, 3, 4, 2, 5, 6, 1'b0);
    take_output();
    check_value(got_dest[0], 32, "first dest lane 0");
    check_value(got_dest[1], 33, "first dest lane 1");
    check_value(got_old[0], 1, "old mapping lane 0");   // identity after reset
    check_value(got_old[1], 2, "old mapping lane 1");
    check_value(got_src1[1], 5, "src1 lane 1");
    check_value({got_rdy2, got_rdy1}, 4'hf, "all sources ready");
endtask

task automatic dependence_and_completion();
    phys_idx_t t0;
    phys_idx_t t1;
    t0 = lowest_free(0);   // tags the first group will receive
    t1 = lowest_free(1);
    send_group(2'b11, 3, 1, 2, 4, 3, 0, 1'b0);   // lane 1 reads lane 0 dest
    take_output();
    check_value(got_src1[1], t0, "in-group forward");
    check_value(got_rdy1[1], 1'b0, "in-group source not ready");
    send_group(2'b01, 5, 4, 3, 0, 0, 0, 1'b0);
    take_output();
    check_value(got_src1[0], t1, "earlier group dest");
    check_value(got_rdy1[0], 1'b0, "earlier dest not ready");
    check_value(got_src2[0], t0, "earlier group dest in src2");
    @(negedge clock);
    complete_valid  = 2'b01;   // result bus brings t0
    complete_tag[0] = t0;
    @(negedge clock);
    complete_valid  = 2'b00;
    send_group(2'b01, 6, 3, 0, 0, 0, 0, 1'b0);
    take_output();
    check_value(got_src1[0], t0, "mapping after completion");
    check_value(got_rdy1[0], 1'b1, "ready after completion");
endtask

task automatic exhaustion_and_retire();
    int        i;
    int        start;
    phys_idx_t r0;
    phys_idx_t r1;
    i = 0;
    while (free_total() > 0) begin
        send_group(free_total() >= 2 ? 2'b11 : 2'b01, arch_idx_t'(i % 32), 1, 2,
                   arch_idx_t'((i + 9) % 32), 3, 4, 1'b0);
        take_output();
        i++;
    end
    @(negedge clock);
    start = n_accepted;
    drive_group(2'b11, 7, 8, 9, 10, 11, 12, 1'b0);
    expect_blocked(6);
    r0 = old_q.pop_front();
    r1 = old_q.pop_front();
    @(negedge clock);
    retire_count  = 2;
    retire_tag[0] = r0;
    retire_tag[1] = r1;
    @(negedge clock);
    retire_count  = 0;
    wait_accept(start);
    take_output();
    check_value(got_dest[0], (r0 < r1) ? r0 : r1, "lower retired tag reused");
    check_value(got_dest[1], (r0 < r1) ? r1 : r0, "upper retired tag reused");
    repeat (10) begin   // give back twenty registers for later tests
        @(negedge clock);
        retire_count  = 2;
        retire_tag[0] = old_q.pop_front();
        retire_tag[1] = old_q.pop_front();
    end
    @(negedge clock);
    retire_count = 0;
endtask

task automatic output_backpressure();
    phys_idx_t e [4];
    int        start;
    for (int k = 0; k < 4; k++) e[k] = lowest_free(k);
    @(negedge clock);
    out_ready = 1'b0;
    send_group(2'b11, 13, 1, 2, 14, 3, 4, 1'b0);
    start = n_accepted;
    drive_group(2'b11, 15, 13, 14, 16, 15, 0, 1'b0);   // second group waits
    expect_blocked(5);
    check_value(out_dest_phys[0], e[0], "output held under back-pressure");
    out_ready = 1'b1;
    wait_accept(start);
    take_output();
    for (int k = 0; k < 4; k++) begin
        check_value(dest_log[dest_log.size() - 4 + k], e[k], "delivery order");
    end
endtask

task automatic branch_restore();
    phys_idx_t pre7;
    phys_idx_t ck5;
    phys_idx_t ck6;
    phys_idx_t g2 [2];
    phys_idx_t keep [2];
    pre7  = m_map[7];
    ck5   = lowest_free(0);   // checkpointed group takes the two lowest
    ck6   = lowest_free(1);
    g2[0] = lowest_free(2);   // wrong-path group takes the next two
    g2[1] = lowest_free(3);
    send_group(2'b11, 5, 0, 0, 6, 0, 0, 1'b1);   // checkpointed group
    take_output();
    send_group(2'b11, 5, 0, 0, 7, 0, 0, 1'b0);   // wrong path
    take_output();
    @(negedge clock);
    restore = 1'b1;
    @(negedge clock);
    restore = 1'b0;
    send_group(2'b11, 8, 5, 6, 9, 7, 0, 1'b0);
    take_output();
    check_value(got_src1[0], ck5, "restored mapping of 5");
    check_value(got_src2[0], ck6, "restored mapping of 6");
    check_value(got_src1[1], pre7, "restored mapping of 7");
    check_value(got_dest[0], g2[0], "wrong-path tag freed in lane 0");
    check_value(got_dest[1], g2[1], "wrong-path tag freed in lane 1");
    keep[1] = old_q.pop_back();   // squashed group never retires
    keep[0] = old_q.pop_back();
    void'(old_q.pop_back());
    void'(old_q.pop_back());
    old_q.push_back(keep[0]);
    old_q.push_back(keep[1]);
endtask

task automatic random_traffic();
    logic [31:0] r;
    int          k;
    for (int c = 0; c < 200; c++) begin
        @(negedge clock);
        r = $random(seed);
        in_valid      = r[0];
        in_lane_valid = r[1] ? 2'b11 : 2'b01;
        in_dest       = {r[11:7], r[6:2]};
        in_src1       = {r[21:17], r[16:12]};
        in_src2       = {r[31:27], r[26:22]};
        r = $random(seed);
        out_ready      = (r[1:0] != 2'b00);   // ready three quarters of the time
        complete_valid = r[3:2];
        complete_tag   = {r[15:10], r[9:4]};
        k = int'(r[17:16]);
        if (k > 2) k = 2;
        if (k > old_q.size()) k = old_q.size();
        retire_count = lane_count_t'(k);
        for (int l = 0; l < k; l++) retire_tag[l] = old_q.pop_front();
    end
    @(negedge clock);
    in_valid       = 1'b0;
    out_ready      = 1'b1;
    complete_valid = '0;
    retire_count   = '0;
    repeat (3) @(negedge clock);   // drain the output register
endtask

// ==== tests/rename_unit_tb.sv ====
`timescale 1ns/10ps

// rename unit testbench with a model of the map, free and complete lists beside the DUT
module rename_unit_tb
    import rename_pkg::*;
();

    logic                  clock;
    logic                  reset;
    logic                  in_valid;
    logic [lanes-1:0]      in_lane_valid;
    arch_idx_t [lanes-1:0] in_dest;
    arch_idx_t [lanes-1:0] in_src1;
    arch_idx_t [lanes-1:0] in_src2;
    logic                  in_checkpoint;
    logic                  in_ready;
    logic                  out_valid;
    logic [lanes-1:0]      out_lane_valid;
    phys_idx_t [lanes-1:0] out_dest_phys;
    phys_idx_t [lanes-1:0] out_old_phys;
    phys_idx_t [lanes-1:0] out_src1_phys;
    phys_idx_t [lanes-1:0] out_src2_phys;
    logic [lanes-1:0]      out_src1_ready;
    logic [lanes-1:0]      out_src2_ready;
    logic                  out_ready;
    logic [lanes-1:0]      complete_valid;
    phys_idx_t [lanes-1:0] complete_tag;
    lane_count_t           retire_count;
    phys_idx_t [lanes-1:0] retire_tag;
    logic                  restore;

    phys_idx_t             m_map [arch_regs];   // model map table
    phys_idx_t             s_map [arch_regs];   // model checkpoint copy
    logic [phys_regs-1:0]  m_free;
    logic [phys_regs-1:0]  m_comp;
    logic [phys_regs-1:0]  s_free;
    logic                  exp_valid;           // expected output register
    logic [lanes-1:0]      e_lane_valid;
    logic [lanes-1:0]      e_rdy1;
    logic [lanes-1:0]      e_rdy2;
    phys_idx_t [lanes-1:0] e_dest;
    phys_idx_t [lanes-1:0] e_old;
    phys_idx_t [lanes-1:0] e_src1;
    phys_idx_t [lanes-1:0] e_src2;
    phys_idx_t [lanes-1:0] got_dest;            // last delivered group
    phys_idx_t [lanes-1:0] got_old;
    phys_idx_t [lanes-1:0] got_src1;
    phys_idx_t [lanes-1:0] got_src2;
    logic [lanes-1:0]      got_rdy1;
    logic [lanes-1:0]      got_rdy2;
    phys_idx_t             old_q [$];           // old tags waiting to retire
    phys_idx_t             dest_log [$];        // delivered dest tags in order
    int                    n_accepted;
    int                    n_delivered;
    int                    wait_limit;
    int                    seed;

    rename_unit i_dut (.*);

    initial clock = 1'b0;
    always #4 clock = ~clock;

    function automatic int free_total();
        return $countones(m_free);
    endfunction

    // n-th lowest free register counting from 0
    function automatic phys_idx_t lowest_free(input int skip);
        int seen;
        seen = 0;
        for (int b = 0; b < phys_regs; b++) begin
            if (m_free[b]) begin
                if (seen == skip) return phys_idx_t'(b);
                seen++;
            end
        end
        return '0;
    endfunction

    function automatic logic bus_hit(input phys_idx_t tag);
        logic hit;
        hit = 1'b0;
        for (int c = 0; c < lanes; c++) hit = hit | (complete_valid[c] && complete_tag[c] == tag);
        return hit;
    endfunction

    // a lower lane of the offered group writes this arch reg
    function automatic logic made_earlier(input int lane, input arch_idx_t arch);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < lane; w++) hit = hit | (in_lane_valid[w] && in_dest[w] == arch);
        return hit;
    endfunction

    task automatic model_reset();
        for (int a = 0; a < arch_regs; a++) begin
            m_map[a] = phys_idx_t'(a);
            s_map[a] = phys_idx_t'(a);
        end
        for (int r = 0; r < phys_regs; r++) begin
            m_free[r] = (r >= arch_regs);   // upper half free
            m_comp[r] = (r < arch_regs);    // lower half holds arch values
        end
        s_free    = m_free;
        exp_valid = 1'b0;
    endtask

    task automatic model_step();
        int                   need;
        logic                 ready_exp;
        logic                 accept;
        logic [phys_regs-1:0] nf;
        logic [phys_regs-1:0] nc;
        phys_idx_t            map_n [arch_regs];
        need = 0;
        for (int l = 0; l < lanes; l++) need += int'(in_lane_valid[l]);
        ready_exp = !restore && (!exp_valid || out_ready) && (free_total() >= need);
        check_value(in_ready, ready_exp, "in_ready");
        check_value(out_valid, exp_valid, "out_valid");
        if (exp_valid) begin
            check_value(out_lane_valid, e_lane_valid, "out_lane_valid");
            for (int l = 0; l < lanes; l++) begin
                if (e_lane_valid[l]) begin
                    check_value(out_dest_phys[l], e_dest[l], "out_dest_phys");
                    check_value(out_old_phys[l], e_old[l], "out_old_phys");
                    check_value(out_src1_phys[l], e_src1[l], "out_src1_phys");
                    check_value(out_src2_phys[l], e_src2[l], "out_src2_phys");
                    check_value(out_src1_ready[l], e_rdy1[l], "out_src1_ready");
                    check_value(out_src2_ready[l], e_rdy2[l], "out_src2_ready");
                end
            end
            if (out_ready) begin   // delivered at this edge
                n_delivered++;
                got_dest = out_dest_phys;
                got_old  = out_old_phys;
                got_src1 = out_src1_phys;
                got_src2 = out_src2_phys;
                got_rdy1 = out_src1_ready;
                got_rdy2 = out_src2_ready;
                for (int l = 0; l < lanes; l++) begin
                    if (e_lane_valid[l]) begin
                        old_q.push_back(e_old[l]);
                        dest_log.push_back(e_dest[l]);
                    end
                end
            end
        end
        accept = in_valid && ready_exp;
        nf     = m_free;
        nc     = m_comp;
        map_n  = m_map;
        for (int l = 0; l < lanes; l++) begin
            if (complete_valid[l]) nc[complete_tag[l]] = 1'b1;
        end
        if (accept) begin
            n_accepted++;
            e_lane_valid = in_lane_valid;
            for (int l = 0; l < lanes; l++) begin
                if (in_lane_valid[l]) begin
                    e_src1[l] = map_n[in_src1[l]];   // map_n already holds lower lanes
                    e_src2[l] = map_n[in_src2[l]];
                    e_old[l]  = map_n[in_dest[l]];
                    e_rdy1[l] = (m_comp[e_src1[l]] || bus_hit(e_src1[l]))
                                && !made_earlier(l, in_src1[l]);
                    e_rdy2[l] = (m_comp[e_src2[l]] || bus_hit(e_src2[l]))
                                && !made_earlier(l, in_src2[l]);
                    e_dest[l] = lowest_free(l);
                    map_n[in_dest[l]] = e_dest[l];
                    nf[e_dest[l]] = 1'b0;
                    nc[e_dest[l]] = 1'b0;            // new value not produced yet
                end
            end
        end
        for (int l = 0; l < lanes; l++) begin
            if (l < int'(retire_count)) nf[retire_tag[l]] = 1'b1;
        end
        m_free = restore ? (nf | s_free) : nf;
        m_comp = nc;
        m_map  = restore ? s_map : map_n;
        if (accept && in_checkpoint) begin
            s_map  = map_n;
            s_free = nf;
        end
        if (restore) exp_valid = 1'b0;
        else if (accept) exp_valid = 1'b1;
        else if (out_ready) exp_valid = 1'b0;
    endtask

    always @(posedge clock) begin
        if (reset) model_reset();
        else model_step();
    end

    `include "rename_unit_tasks.svh"

    initial begin
        seed           = 32'h6187aa93;
        wait_limit     = 50;
        n_accepted     = 0;
        n_delivered    = 0;
        reset          = 1'b1;
        in_valid       = 1'b0;
        in_lane_valid  = '0;
        in_dest        = '0;
        in_src1        = '0;
        in_src2        = '0;
        in_checkpoint  = 1'b0;
        out_ready      = 1'b1;
        complete_valid = '0;
        complete_tag   = '0;
        retire_count   = '0;
        retire_tag     = '0;
        restore        = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        first_group_after_reset();
        dependence_and_completion();
        exhaustion_and_retire();
        output_backpressure();
        branch_restore();
        random_traffic();
        @(negedge clock);
        $display("Simulation PASSED");
        $finish;
    end

endmodule
